//--- src/lc3b_pkg.sv
package lc3b_pkg;

    typedef logic [15:0] lc3b_word;

    // n, z and p from msb down.
    typedef logic [2:0] lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldw  = 4'b0110,
        op_stw  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    // memory address source.
    typedef enum logic [1:0] {
        marmux_alu  = 2'b00,
        marmux_pc   = 2'b01,
        marmux_br   = 2'b10,
        marmux_trap = 2'b11   // zext(trapvect8) << 1.
    } marmux_sel_t;

    // store data source.
    typedef enum logic [1:0] {
        mdrmux_sr2      = 2'b00,
        mdrmux_sr2_byte = 2'b01,  // low byte of sr2 on both lanes.
        mdrmux_alu      = 2'b10
    } mdrmux_sel_t;

    // register file write-back source.
    typedef enum logic [2:0] {
        wbmux_alu       = 3'b000,
        wbmux_load_word = 3'b001,
        wbmux_load_byte = 3'b010,
        wbmux_br_add    = 3'b011,
        wbmux_pc        = 3'b100,
        wbmux_shift     = 3'b101
    } wbmux_sel_t;

    // wishbone byte lane selects.
    localparam logic [1:0] sel_word  = 2'b11;
    localparam logic [1:0] sel_upper = 2'b10;
    localparam logic [1:0] sel_lower = 2'b01;

    localparam lc3b_nzp nzp_reset = 3'b010;  // codes read as zero out of reset.

endpackage

//--- src/mem_access.sv
module mem_access (
    input  lc3b_pkg::lc3b_opcode  opcode,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  lc3b_pkg::marmux_sel_t marmux_sel,
    input  lc3b_pkg::mdrmux_sel_t mdrmux_sel,
    input  lc3b_pkg::lc3b_word    alu_out,
    input  lc3b_pkg::lc3b_word    pc_out,
    input  lc3b_pkg::lc3b_word    br_add_out,
    input  lc3b_pkg::lc3b_word    sr2_out,
    input  lc3b_pkg::lc3b_word    instruction,

    // wishbone classic master.
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output lc3b_pkg::lc3b_word    wb_adr,
    output lc3b_pkg::lc3b_word    wb_dat_o,
    output logic [1:0]            wb_sel,
    input  lc3b_pkg::lc3b_word    wb_dat_i,
    input  logic                  wb_ack,

    output lc3b_pkg::lc3b_word    load_word,
    output lc3b_pkg::lc3b_word    load_byte,
    output logic                  stall
);

    lc3b_pkg::lc3b_word mar;
    lc3b_pkg::lc3b_word mdr;
    logic               req;
    logic               byte_access;
    logic               is_stb;

    assign req         = mem_read | mem_write;
    assign is_stb      = (opcode == lc3b_pkg::op_stb);
    assign byte_access = is_stb || (opcode == lc3b_pkg::op_ldb);

    always_comb begin
        case (marmux_sel)
            lc3b_pkg::marmux_alu: mar = alu_out;
            lc3b_pkg::marmux_pc:  mar = pc_out;
            lc3b_pkg::marmux_br:  mar = br_add_out;
            default:              mar = {7'b0, instruction[7:0], 1'b0};  // trap vector.
        endcase
    end

    always_comb begin
        case (mdrmux_sel)
            lc3b_pkg::mdrmux_sr2:      mdr = sr2_out;
            lc3b_pkg::mdrmux_sr2_byte: mdr = {sr2_out[7:0], sr2_out[7:0]};
            default:                   mdr = alu_out;
        endcase
    end

    // byte accesses pick the lane from address bit 0.
    always_comb begin
        if (byte_access) begin
            wb_sel = mar[0] ? lc3b_pkg::sel_upper : lc3b_pkg::sel_lower;
        end else begin
            wb_sel = lc3b_pkg::sel_word;
        end
    end

    // stb puts the source byte on both lanes and sel masks the one not written.
    assign wb_dat_o = is_stb ? {mdr[7:0], mdr[7:0]} : mdr;
    assign wb_adr   = mar;

    // inputs are held by the previous stage while stalled, so the bus stays steady.
    assign wb_cyc = req;
    assign wb_stb = req;
    assign wb_we  = mem_write;

    assign stall = req & ~wb_ack;  // released in the ack cycle.

    assign load_word = wb_dat_i;
    assign load_byte = mar[0] ? {8'h00, wb_dat_i[15:8]} : {8'h00, wb_dat_i[7:0]};

endmodule

//--- src/shift_unit.sv
module shift_unit (
    input  lc3b_pkg::lc3b_word sr1_out,
    input  lc3b_pkg::lc3b_word instruction,
    output lc3b_pkg::lc3b_word shift_out
);

    logic [3:0] amount;
    logic       left;
    logic       arith;

    // shf fields: bit 4 direction, bit 5 arithmetic, imm4 amount.
    assign amount = instruction[3:0];
    assign left   = ~instruction[4];
    assign arith  = instruction[5];

    always_comb begin
        if (left) begin
            shift_out = sr1_out << amount;  // lshf.
        end else if (arith) begin
            shift_out = $signed(sr1_out) >>> amount;  // rshfa keeps the sign.
        end else begin
            shift_out = sr1_out >> amount;  // rshfl.
        end
    end

endmodule

//--- src/writeback_unit.sv
module writeback_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_pkg::lc3b_opcode opcode,
    input  lc3b_pkg::wbmux_sel_t wbmux_sel,
    input  logic                 load_cc,
    input  logic                 stall,
    input  lc3b_pkg::lc3b_word   alu_out,
    input  lc3b_pkg::lc3b_word   br_add_out,
    input  lc3b_pkg::lc3b_word   pc_out,
    input  lc3b_pkg::lc3b_word   load_word,
    input  lc3b_pkg::lc3b_word   load_byte,
    input  lc3b_pkg::lc3b_word   shift_out,
    input  lc3b_pkg::lc3b_nzp    dest,
    output lc3b_pkg::lc3b_word   wb_value,
    output logic                 br_en
);

    lc3b_pkg::lc3b_nzp gen_cc;
    lc3b_pkg::lc3b_nzp cc;

    always_comb begin
        case (wbmux_sel)
            lc3b_pkg::wbmux_load_word: wb_value = load_word;
            lc3b_pkg::wbmux_load_byte: wb_value = load_byte;
            lc3b_pkg::wbmux_br_add:    wb_value = br_add_out;
            lc3b_pkg::wbmux_pc:        wb_value = pc_out;
            lc3b_pkg::wbmux_shift:     wb_value = shift_out;
            default:                   wb_value = alu_out;
        endcase
    end

    always_comb begin
        if (wb_value[15]) begin
            gen_cc = 3'b100;
        end else if (wb_value == 16'h0000) begin
            gen_cc = 3'b010;
        end else begin
            gen_cc = 3'b001;
        end
    end

    // load data is only valid once ack ends the stall.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cc <= lc3b_pkg::nzp_reset;
        end else if (load_cc && !stall) begin
            cc <= gen_cc;
        end
    end

    // branch taken when any requested code is set.
    assign br_en = (opcode == lc3b_pkg::op_br) && (|(cc & dest));

endmodule

//--- src/mem_stage.sv
module mem_stage (
    input  logic                  clk,
    input  logic                  rst_n,

    input  lc3b_pkg::lc3b_word    alu_out,
    input  lc3b_pkg::lc3b_word    pc_out,
    input  lc3b_pkg::lc3b_word    br_add_out,
    input  lc3b_pkg::lc3b_word    sr1_out,
    input  lc3b_pkg::lc3b_word    sr2_out,
    input  lc3b_pkg::lc3b_word    instruction,
    input  lc3b_pkg::lc3b_nzp     dest,

    input  lc3b_pkg::lc3b_opcode  opcode,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  lc3b_pkg::marmux_sel_t marmux_sel,
    input  lc3b_pkg::mdrmux_sel_t mdrmux_sel,
    input  lc3b_pkg::wbmux_sel_t  wbmux_sel,
    input  logic                  load_cc,

    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output lc3b_pkg::lc3b_word    wb_adr,
    output lc3b_pkg::lc3b_word    wb_dat_o,
    output logic [1:0]            wb_sel,
    input  lc3b_pkg::lc3b_word    wb_dat_i,
    input  logic                  wb_ack,

    output lc3b_pkg::lc3b_word    wb_value,
    output logic                  br_en,
    output logic                  stall
);

    lc3b_pkg::lc3b_word load_word;
    lc3b_pkg::lc3b_word load_byte;
    lc3b_pkg::lc3b_word shift_out;

    mem_access i_mem_access (
        .opcode      (opcode),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .marmux_sel  (marmux_sel),
        .mdrmux_sel  (mdrmux_sel),
        .alu_out     (alu_out),
        .pc_out      (pc_out),
        .br_add_out  (br_add_out),
        .sr2_out     (sr2_out),
        .instruction (instruction),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_o    (wb_dat_o),
        .wb_sel      (wb_sel),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .load_word   (load_word),
        .load_byte   (load_byte),
        .stall       (stall)
    );

    shift_unit i_shift_unit (
        .sr1_out     (sr1_out),
        .instruction (instruction),
        .shift_out   (shift_out)
    );

    writeback_unit i_writeback_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .opcode     (opcode),
        .wbmux_sel  (wbmux_sel),
        .load_cc    (load_cc),
        .stall      (stall),
        .alu_out    (alu_out),
        .br_add_out (br_add_out),
        .pc_out     (pc_out),
        .load_word  (load_word),
        .load_byte  (load_byte),
        .shift_out  (shift_out),
        .dest       (dest),
        .wb_value   (wb_value),
        .br_en      (br_en)
    );

endmodule

//--- verif/wb_mem_model.sv
module wb_mem_model (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  lc3b_pkg::lc3b_word wb_adr,
    input  lc3b_pkg::lc3b_word wb_dat_o,
    input  logic [1:0]         wb_sel,
    output lc3b_pkg::lc3b_word wb_dat_i,
    output logic               wb_ack
);
    timeunit 1ns;
    timeprecision 1ns;

    lc3b_pkg::lc3b_word mem [256];
    logic [7:0]         index;
    logic [1:0]         wait_left;
    logic               busy;
    int unsigned        seed;

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    assign index    = wb_adr[8:1];  // byte address to word index.
    assign wb_dat_i = mem[index];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // every word holds its own byte address xor a5c3.
            for (int i = 0; i < 256; i++) begin
                mem[8'(i)] <= 16'(2 * i) ^ 16'hA5C3;
            end
            seed      <= 32'd64773;
            wait_left <= 2'd0;
            busy      <= 1'b0;
            wb_ack    <= 1'b0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;  // single cycle ack.
            busy   <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!busy) begin
                seed      <= lcg_next(seed);
                wait_left <= 2'(lcg_next(seed) >> 16);  // 0 to 3 wait cycles.
                busy      <= 1'b1;
            end else if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                wb_ack <= 1'b1;
                if (wb_we && wb_sel[0]) mem[index][7:0] <= wb_dat_o[7:0];
                if (wb_we && wb_sel[1]) mem[index][15:8] <= wb_dat_o[15:8];
            end
        end
    end

endmodule

//--- verif/mem_stage_tb.sv
module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ns;

    logic                  clk = 1'b0;
    logic                  rst_n;
    lc3b_pkg::lc3b_word    alu_out, pc_out, br_add_out, sr1_out, sr2_out, instruction;
    lc3b_pkg::lc3b_nzp     dest;
    lc3b_pkg::lc3b_opcode  opcode;
    logic                  mem_read, mem_write, load_cc;
    lc3b_pkg::marmux_sel_t marmux_sel;
    lc3b_pkg::mdrmux_sel_t mdrmux_sel;
    lc3b_pkg::wbmux_sel_t  wbmux_sel;
    logic                  wb_cyc, wb_stb, wb_we, wb_ack, br_en, stall;
    lc3b_pkg::lc3b_word    wb_adr, wb_dat_o, wb_dat_i, wb_value;
    logic [1:0]            wb_sel;
    int unsigned           rand_state = 32'd64773;
    int                    errors = 0;
    int                    tests = 0;
    int                    failed = 0;

    // negative, zero and positive samples with their codes.
    lc3b_pkg::lc3b_word    cc_values [3] = '{16'h8001, 16'h0000, 16'h1234};
    logic [2:0]            cc_codes [3] = '{3'b100, 3'b010, 3'b001};

    always #50 clk = ~clk;

    mem_stage i_mem_stage (.*);
    wb_mem_model i_mem (.*);

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic lc3b_pkg::lc3b_word random_word();
        rand_state = lcg_next(rand_state);
        return rand_state[31:16];
    endfunction

    // one bit position per step.
    function automatic lc3b_pkg::lc3b_word shift_reference(input lc3b_pkg::lc3b_word value,
            input int amount, input logic right, input logic arith);
        lc3b_pkg::lc3b_word result;
        result = value;
        for (int i = 0; i < amount; i++) begin
            if (right) begin
                result = {arith & result[15], result[15:1]};
            end else begin
                result = {result[14:0], 1'b0};
            end
        end
        return result;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_value(input string what, input lc3b_pkg::lc3b_word got,
                               input lc3b_pkg::lc3b_word expected);
        assert (got === expected)
            else report_error($sformatf("%s got %h, expected %h", what, got, expected));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic bus_access(input lc3b_pkg::lc3b_opcode op, input logic write,
                              input lc3b_pkg::lc3b_word addr, input lc3b_pkg::lc3b_word data,
                              input lc3b_pkg::wbmux_sel_t source, input logic [1:0] lanes,
                              output lc3b_pkg::lc3b_word value);
        int                 cycles;
        lc3b_pkg::lc3b_word store_data;
        cycles = 0;
        // stb carries its byte on both lanes.
        store_data = (op == lc3b_pkg::op_stb) ? {data[7:0], data[7:0]} : data;
        @(posedge clk);
        opcode     <= op;
        mem_read   <= !write;
        mem_write  <= write;
        marmux_sel <= lc3b_pkg::marmux_alu;
        mdrmux_sel <= (op == lc3b_pkg::op_stb) ? lc3b_pkg::mdrmux_sr2_byte : lc3b_pkg::mdrmux_sr2;
        alu_out    <= addr;
        sr2_out    <= data;
        wbmux_sel  <= source;
        do begin
            @(negedge clk);
            cycles++;
            assert (wb_cyc && wb_stb && wb_we == write)
                else report_error("strobes not held during the bus cycle");
            assert (wb_sel == lanes)
                else report_error($sformatf("wb_sel %b, expected %b", wb_sel, lanes));
            assert (wb_adr == addr)
                else report_error($sformatf("wb_adr %h, expected %h", wb_adr, addr));
            if (write) begin
                assert (wb_dat_o == store_data)
                    else report_error($sformatf("wb_dat_o %h, expected %h",
                                                wb_dat_o, store_data));
            end
            assert (stall == !wb_ack) else report_error("stall does not end with wb_ack");
        end while (stall && cycles < 20);
        if (stall) begin
            errors++;
            $display("timeout: no wb_ack within 20 cycles of the request at %0t ns", $time);
        end
        value = wb_value;  // ack cycle.
        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        @(negedge clk);
        assert (!wb_cyc && !stall) else report_error("bus still active after the ack cycle");
    endtask

    initial begin
        lc3b_pkg::lc3b_word value;
        lc3b_pkg::lc3b_word operand;
        lc3b_pkg::lc3b_word addr;
        int                 amount;
        int                 mark;
        rst_n <= 1'b0;
        {alu_out, pc_out, br_add_out, sr1_out, sr2_out, instruction} <= '0;
        {mem_read, mem_write, load_cc} <= '0;
        dest       <= '0;
        opcode     <= lc3b_pkg::op_add;
        marmux_sel <= lc3b_pkg::marmux_alu;
        mdrmux_sel <= lc3b_pkg::mdrmux_sr2;
        wbmux_sel  <= lc3b_pkg::wbmux_alu;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!wb_cyc && !stall && !br_en) else report_error("bus or branch active after reset");

        mark = errors;
        bus_access(lc3b_pkg::op_ldw, 1'b0, 16'h0046, 16'h0000, lc3b_pkg::wbmux_load_word,
                   2'b11, value);
        check_value("ldw", value, 16'h0046 ^ 16'hA5C3);
        finish_test("ldw word", mark);

        mark = errors;
        operand = 16'h0012 ^ 16'hA5C3;
        bus_access(lc3b_pkg::op_ldb, 1'b0, 16'h0013, 16'h0000, lc3b_pkg::wbmux_load_byte,
                   2'b10, value);
        check_value("ldb odd", value, {8'h00, operand[15:8]});
        operand = 16'h0020 ^ 16'hA5C3;
        bus_access(lc3b_pkg::op_ldb, 1'b0, 16'h0020, 16'h0000, lc3b_pkg::wbmux_load_byte,
                   2'b01, value);
        check_value("ldb even", value, {8'h00, operand[7:0]});
        finish_test("ldb odd and even", mark);

        mark = errors;
        bus_access(lc3b_pkg::op_stb, 1'b1, 16'h0031, 16'h3C7E, lc3b_pkg::wbmux_alu, 2'b10, value);
        operand = 16'h0030 ^ 16'hA5C3;
        bus_access(lc3b_pkg::op_ldw, 1'b0, 16'h0030, 16'h0000, lc3b_pkg::wbmux_load_word,
                   2'b11, value);
        check_value("ldw after stb", value, {8'h7E, operand[7:0]});
        finish_test("stb then ldw", mark);

        // random delays from the model exercise each ack distance.
        mark = errors;
        for (int n = 0; n < 8; n++) begin
            addr = (random_word() & 16'h00FE) | 16'h0100;
            bus_access(lc3b_pkg::op_ldw, 1'b0, addr, 16'h0000, lc3b_pkg::wbmux_load_word,
                       2'b11, value);
            check_value("ldw random", value, addr ^ 16'hA5C3);
        end
        finish_test("stall and strobes", mark);

        mark = errors;
        for (int mode = 0; mode < 3; mode++) begin
            for (int n = 0; n < 4; n++) begin
                operand = random_word();
                amount  = int'(random_word() & 16'h000F);
                @(posedge clk);
                opcode      <= lc3b_pkg::op_shf;
                wbmux_sel   <= lc3b_pkg::wbmux_shift;
                sr1_out     <= operand;
                instruction <= {4'b1101, 6'b000000, mode == 2, mode != 0, 4'(amount)};
                @(negedge clk);
                check_value("shf", wb_value, shift_reference(operand, amount, mode != 0, mode == 2));
                assert (!wb_cyc) else report_error("bus cycle started for shf");
            end
        end
        finish_test("shf", mark);

        mark = errors;
        for (int v = 0; v < 3; v++) begin
            @(posedge clk);
            opcode    <= lc3b_pkg::op_add;
            wbmux_sel <= lc3b_pkg::wbmux_alu;
            alu_out   <= cc_values[v];
            load_cc   <= 1'b1;
            @(posedge clk);
            load_cc <= 1'b0;
            opcode  <= lc3b_pkg::op_br;
            for (int m = 0; m < 8; m++) begin
                dest <= 3'(m);
                @(negedge clk);
                assert (br_en == (|(cc_codes[v] & 3'(m))))
                    else report_error($sformatf("br_en %b for codes %b, mask %0d",
                                                br_en, cc_codes[v], m));
                @(posedge clk);
            end
            opcode <= lc3b_pkg::op_add;
            dest   <= 3'b111;
            @(negedge clk);
            assert (!br_en) else report_error("br_en high for add");
        end
        finish_test("condition codes and branch", mark);

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- mem_stage.f
src/lc3b_pkg.sv
src/mem_access.sv
src/shift_unit.sv
src/writeback_unit.sv
src/mem_stage.sv
verif/wb_mem_model.sv
verif/mem_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mem_stage testbench with verilator, then scan the log.
verilator --binary --timing --assert -f mem_stage.f --top-module mem_stage_tb \
    -o mem_stage_sim || exit 1
./obj_dir/mem_stage_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log || exit 1
exit 0
